// File: filelist.f
common/mem_sys_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
src/main_mem.sv
src/mem_system.sv
dv/tb_clk_gen.sv
dv/mem_system_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mem_system_tb -f filelist.f \
	--Mdir obj_dir -o mem_system_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/mem_system_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0

// File: dv/mem_system_tb.sv
`timescale 1ns/1ps

module mem_system_tb;
	import mem_sys_pkg::*;

	typedef struct packed {
		logic done;
		logic stall;
		logic hit;
		logic err;
	} flags_t;

	localparam int NUM_RAND  = 200;
	localparam int NUM_REQS  = 1 + 2 + 5 + 8 + 1 + NUM_RAND;
	localparam int TIMEOUT   = 40 * NUM_REQS;
	localparam int CLEAN_LAT = 8;   // ENABLE, REQ0..FILL3, then DONE
	localparam int DIRTY_LAT = 12;  // Four write-back cycles on top

	logic              clk;
	logic              arst_n;
	cpu_req_t          req;
	logic [DATA_W-1:0] data_out;
	logic              done;
	logic              stall;
	logic              cache_hit;
	logic              err;

	// CPU view of memory plus a shadow of the tag state
	logic [DATA_W-1:0] ref_mem  [1 << (ADDR_W-1)];
	logic [TAG_W-1:0]  sh_tag   [NUM_WAYS][NUM_SETS];
	logic              sh_valid [NUM_WAYS][NUM_SETS];
	logic              sh_dirty [NUM_WAYS][NUM_SETS];
	logic              sh_victim;
	logic [31:0]       lfsr_q;
	int                cycle_cnt = 0;

	tb_clk_gen clk_gen_i (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mem_system dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
			abort_run();
		end
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [DATA_W-1:0] rand_bits(int n);
		logic [DATA_W-1:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);  // One step per bit
			val    = {val[DATA_W-2:0], lfsr_q[0]};
		end
		return val;
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(logic [TAG_W-1:0] tag,
			logic [INDEX_W-1:0] idx, logic [1:0] word);
		return {tag, idx, word, 1'b0};
	endfunction

	task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("error: %0d ns %s: data %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flags(input flags_t got, input flags_t exp, input string what);
		if (got !== exp) begin
			$display("error: %0d ns %s: done/stall/hit/err %b, expected %b",
				$time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cycles(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("error: %0d ns %s: done after %0d cycles, expected %0d",
				$time, what, got, exp);
			abort_run();
		end
	endtask

	// Predicts flags, latency and read data, then updates the shadow
	task automatic model_access(input logic [ADDR_W-1:0] addr, input logic wr,
			input logic [DATA_W-1:0] wdata, output flags_t exp_f, output int exp_lat,
			output logic [DATA_W-1:0] exp_data);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0]   tag;
		int                 way;
		idx      = addr[OFFSET_W +: INDEX_W];
		tag      = addr[ADDR_W-1 -: TAG_W];
		exp_f    = '0;
		exp_f.done = 1'b1;
		exp_lat  = 0;
		exp_data = ref_mem[addr[ADDR_W-1:1]];
		way      = -1;
		if (addr[0]) begin
			exp_f.err = 1'b1;  // Rejected at once
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (sh_valid[w][idx] && sh_tag[w][idx] == tag) begin
					way = w;
				end
			end
			if (way >= 0) begin
				exp_f.hit = 1'b1;
			end else begin
				if (!sh_valid[0][idx]) begin
					way = 0;
				end else if (!sh_valid[1][idx]) begin
					way = 1;
				end else begin
					way = sh_victim ? 1 : 0;
				end
				exp_lat = (sh_valid[way][idx] && sh_dirty[way][idx]) ? DIRTY_LAT : CLEAN_LAT;
				sh_tag[way][idx]   = tag;
				sh_valid[way][idx] = 1'b1;
				sh_dirty[way][idx] = 1'b0;
			end
			if (wr) begin
				sh_dirty[way][idx]          = 1'b1;
				ref_mem[addr[ADDR_W-1:1]] = wdata;
			end
		end
		sh_victim = ~sh_victim;  // Every done moves the pointer
	endtask

	task automatic access(input logic [ADDR_W-1:0] addr, input logic wr,
			input logic [DATA_W-1:0] wdata, output int lat);
		flags_t            exp_f;
		flags_t            busy_f;
		int                exp_lat;
		logic [DATA_W-1:0] exp_data;
		string             what;
		model_access(addr, wr, wdata, exp_f, exp_lat, exp_data);
		what   = $sformatf("%s addr %h", wr ? "write" : "read", addr);
		busy_f = '0;
		busy_f.stall = 1'b1;
		@(posedge clk);
		req.addr  <= addr;
		req.wdata <= wdata;
		req.rd    <= ~wr;
		req.wr    <= wr;
		@(negedge clk);
		lat = 0;
		while (!done) begin
			check_flags({done, stall, cache_hit, err}, busy_f, what);
			@(posedge clk);
			req.rd <= 1'b0;  // One-cycle pulse
			req.wr <= 1'b0;
			@(negedge clk);
			lat++;
		end
		check_flags({done, stall, cache_hit, err}, exp_f, what);
		check_cycles(lat, exp_lat, what);
		if (!wr && !exp_f.err) begin
			check_data(data_out, exp_data, what);
		end
		@(posedge clk);
		req.rd <= 1'b0;
		req.wr <= 1'b0;
	endtask

	task automatic test_reset_cold_read();
		int lat;
		check_flags({done, stall, cache_hit, err}, '0, "state after reset");
		access(16'h0120, 1'b0, '0, lat);
		check_cycles(lat, CLEAN_LAT, "cold read miss");
	endtask

	task automatic test_write_then_read();
		int lat;
		access(16'h2244, 1'b1, 16'hbeef, lat);
		access(16'h2244, 1'b0, '0, lat);
		check_cycles(lat, 0, "read hit after write");
	endtask

	task automatic test_dirty_eviction();
		int lat;
		access(make_addr(5'd1, 8'h31, 2'd0), 1'b1, 16'ha001, lat);
		access(make_addr(5'd2, 8'h31, 2'd0), 1'b1, 16'ha002, lat);
		access(make_addr(5'd3, 8'h31, 2'd0), 1'b1, 16'ha003, lat);
		check_cycles(lat, DIRTY_LAT, "third write to one set");
		access(make_addr(5'd1, 8'h31, 2'd0), 1'b0, '0, lat);  // One of these comes from memory
		access(make_addr(5'd2, 8'h31, 2'd0), 1'b0, '0, lat);
	endtask

	task automatic test_line_words();
		int lat;
		access(make_addr(5'd6, 8'h52, 2'd1), 1'b1, 16'h5101, lat);
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			if (w != 1) begin
				access(make_addr(5'd6, 8'h52, 2'(w)), 1'b1, 16'h5100 + 16'(w), lat);
			end
		end
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			access(make_addr(5'd6, 8'h52, 2'(w)), 1'b0, '0, lat);
		end
	endtask

	task automatic test_odd_addr();
		int lat;
		access(16'h0345, 1'b1, 16'hdead, lat);
	endtask

	task automatic test_random();
		logic [DATA_W-1:0] r_tag;
		logic [DATA_W-1:0] r_idx;
		logic [DATA_W-1:0] r_word;
		logic [DATA_W-1:0] r_wr;
		logic [DATA_W-1:0] r_data;
		int                lat;
		for (int i = 0; i < NUM_RAND; i++) begin
			r_tag  = rand_bits(2);
			r_idx  = rand_bits(1);
			r_word = rand_bits(2);
			r_wr   = rand_bits(1);
			r_data = rand_bits(DATA_W);
			access(make_addr({3'b010, r_tag[1:0]}, {7'h38, r_idx[0]}, r_word[1:0]),
				r_wr[0], r_data, lat);
		end
	endtask

	initial begin
		req       = '0;
		lfsr_q    = 32'd75628;
		sh_victim = 1'b0;
		for (int a = 0; a < (1 << (ADDR_W-1)); a++) begin
			ref_mem[a] = '0;  // Main memory starts at zero
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				sh_tag[w][s]   = '0;
				sh_valid[w][s] = 1'b0;
				sh_dirty[w][s] = 1'b0;
			end
		end
		wait (arst_n === 1'b1);
		@(negedge clk);
		test_reset_cold_read();
		test_write_then_read();
		test_dirty_eviction();
		test_line_words();
		test_odd_addr();
		test_random();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// File: src/mem_system.sv
`timescale 1ns/1ps

module mem_system (
	input  logic                           clk,
	input  logic                           arst_n,
	input  mem_sys_pkg::cpu_req_t          req,
	output logic [mem_sys_pkg::DATA_W-1:0] data_out,
	output logic                           done,
	output logic                           stall,
	output logic                           cache_hit,
	output logic                           err
);
	import mem_sys_pkg::*;

	way_ctrl_t         way_ctrl;
	way_status_t       way_status [NUM_WAYS];
	mem_req_t          mem_req;
	logic [DATA_W-1:0] mem_rdata;

	cache_ctrl ctrl_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (req),
		.way_status (way_status),
		.mem_rdata  (mem_rdata),
		.way_ctrl   (way_ctrl),
		.mem_req    (mem_req),
		.data_out   (data_out),
		.done       (done),
		.stall      (stall),
		.cache_hit  (cache_hit),
		.err        (err)
	);

	// Both ways see the same command, each acts on its own enable
	cache_way way0_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.enable   (way_ctrl.en[0]),
		.way_ctrl (way_ctrl),
		.status   (way_status[0])
	);

	cache_way way1_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.enable   (way_ctrl.en[1]),
		.way_ctrl (way_ctrl),
		.status   (way_status[1])
	);

	main_mem mem_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata)
	);

endmodule

// File: src/main_mem.sv
`timescale 1ns/1ps

module main_mem (
	input  logic                           clk,
	input  logic                           arst_n,
	input  mem_sys_pkg::mem_req_t          mem_req,
	output logic [mem_sys_pkg::DATA_W-1:0] mem_rdata
);
	import mem_sys_pkg::*;

	logic [DATA_W-1:0]     bank_mem [NUM_BANKS][BANK_ROWS] = '{default: '0};
	logic [MEM_LATENCY-2:0] rd_valid_q;
	logic [ADDR_W-1:0]     rd_addr_q [MEM_LATENCY-1];
	logic [DATA_W-1:0]     rdata_q;
	logic [BANK_SEL_W-1:0] wr_bank;
	logic [BANK_SEL_W-1:0] rd_bank;
	logic [ROW_W-1:0]      wr_row;
	logic [ROW_W-1:0]      rd_row;

	// Bank from address bits [2:1]
	assign wr_bank = mem_req.addr[1 +: BANK_SEL_W];
	assign wr_row  = mem_req.addr[ADDR_W-1 -: ROW_W];
	assign rd_bank = rd_addr_q[MEM_LATENCY-2][1 +: BANK_SEL_W];
	assign rd_row  = rd_addr_q[MEM_LATENCY-2][ADDR_W-1 -: ROW_W];

	assign mem_rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (mem_req.wr) begin
			bank_mem[wr_bank][wr_row] <= mem_req.wdata;  // Write lands at this edge
		end
		if (rd_valid_q[MEM_LATENCY-2]) begin
			rdata_q <= bank_mem[rd_bank][rd_row];  // Last pipeline stage
		end
		rd_addr_q[0] <= mem_req.addr;
		for (int i = 1; i < MEM_LATENCY - 1; i++) begin
			rd_addr_q[i] <= rd_addr_q[i-1];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid_q <= '0;
		end else begin
			rd_valid_q[0] <= mem_req.rd;
			for (int i = 1; i < MEM_LATENCY - 1; i++) begin
				rd_valid_q[i] <= rd_valid_q[i-1];
			end
		end
	end

	a_even_addr: assert property (
		@(posedge clk) disable iff (!arst_n) (mem_req.rd || mem_req.wr) |-> !mem_req.addr[0]
	) else $error("main_mem: access to odd address %h", mem_req.addr);

endmodule

// File: cache/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                             clk,
	input  logic                             arst_n,
	input  mem_sys_pkg::cpu_req_t            req,
	input  mem_sys_pkg::way_status_t         way_status [mem_sys_pkg::NUM_WAYS],
	input  logic [mem_sys_pkg::DATA_W-1:0]   mem_rdata,
	output mem_sys_pkg::way_ctrl_t           way_ctrl,
	output mem_sys_pkg::mem_req_t            mem_req,
	output logic [mem_sys_pkg::DATA_W-1:0]   data_out,
	output logic                             done,
	output logic                             stall,
	output logic                             cache_hit,
	output logic                             err
);
	import mem_sys_pkg::*;

	ctrl_state_e         state_q;
	ctrl_state_e         state_d;
	cpu_req_t            req_q;
	logic                victim_q;
	logic                way_sel_q;
	logic                way_sel_d;
	logic [ADDR_W-1:0]   cur_addr;
	logic [DATA_W-1:0]   cpu_wdata;
	logic [OFFSET_W-1:0] way_off;
	logic [OFFSET_W-1:0] mem_off;
	logic [TAG_W-1:0]    mem_tag;
	logic [NUM_WAYS-1:0] sel_onehot;
	logic                req_any;
	logic                misaligned;
	logic                hit_any;
	logic                capture;
	logic                wb_phase;
	logic                rd_phase;
	logic                fill_phase;
	logic                miss_phase;

	// Live request in IDLE, captured request afterwards
	assign cur_addr  = (state_q == IDLE) ? req.addr : req_q.addr;
	assign cpu_wdata = (state_q == IDLE) ? req.wdata : req_q.wdata;

	assign req_any    = req.rd | req.wr;
	assign misaligned = req_any & req.addr[0];
	assign hit_any    = way_status[0].hit | way_status[1].hit;
	assign sel_onehot = NUM_WAYS'(1) << way_sel_q;

	assign wb_phase   = state_q inside {[WB0:WB3]};
	assign rd_phase   = state_q inside {[REQ0:REQ3_FILL1]};
	assign fill_phase = state_q inside {[REQ2_FILL0:FILL3]};
	assign miss_phase = state_q inside {[ENABLE:FILL3]};

	assign data_out = way_status[1].hit ? way_status[1].rdata : way_status[0].rdata;

	always_comb begin
		state_d   = state_q;
		way_sel_d = way_sel_q;
		capture   = 1'b0;
		way_off   = cur_addr[OFFSET_W-1:0];
		mem_off   = '0;
		mem_tag   = cur_addr[ADDR_W-1 -: TAG_W];  // Fill address uses request tag
		done      = 1'b0;
		stall     = miss_phase;
		cache_hit = 1'b0;
		err       = 1'b0;

		way_ctrl.index    = cur_addr[OFFSET_W +: INDEX_W];
		way_ctrl.tag      = cur_addr[ADDR_W-1 -: TAG_W];
		way_ctrl.comp     = 1'b0;
		way_ctrl.write    = 1'b0;
		way_ctrl.fill_sel = 1'b0;
		way_ctrl.en       = '0;
		mem_req.rd        = 1'b0;
		mem_req.wr        = 1'b0;

		case (state_q)
			IDLE: begin
				way_ctrl.comp  = 1'b1;
				way_ctrl.write = req.wr & ~misaligned;
				way_ctrl.en    = (req_any && !misaligned) ? '1 : '0;
				cache_hit      = req_any & ~misaligned & hit_any;
				err            = misaligned;  // Odd address ends the request at once
				done           = cache_hit | misaligned;
				stall          = req_any & ~done;
				capture        = req_any;
				if (stall) begin
					state_d = ENABLE;
				end
			end
			ENABLE: begin
				if (!way_status[0].valid) begin
					way_sel_d = 1'b0;
				end else if (!way_status[1].valid) begin
					way_sel_d = 1'b1;
				end else begin
					way_sel_d = victim_q;
				end
				state_d = (way_status[way_sel_d].valid && way_status[way_sel_d].dirty) ? WB0 : REQ0;
			end
			WB0: begin
				way_off = 3'd0;
				state_d = WB1;
			end
			WB1: begin
				way_off = 3'd2;
				state_d = WB2;
			end
			WB2: begin
				way_off = 3'd4;
				state_d = WB3;
			end
			WB3: begin
				way_off = 3'd6;
				state_d = REQ0;
			end
			REQ0: begin
				mem_off = 3'd0;
				state_d = REQ1;
			end
			REQ1: begin
				mem_off = 3'd2;
				state_d = REQ2_FILL0;
			end
			REQ2_FILL0: begin
				mem_off = 3'd4;
				way_off = 3'd0;  // Data of REQ0 arrives now
				state_d = REQ3_FILL1;
			end
			REQ3_FILL1: begin
				mem_off = 3'd6;
				way_off = 3'd2;
				state_d = FILL2;
			end
			FILL2: begin
				way_off = 3'd4;
				state_d = FILL3;
			end
			FILL3: begin
				way_off = 3'd6;
				state_d = DONE;
			end
			DONE: begin
				way_ctrl.comp  = 1'b1;  // Replay the access on the filled line
				way_ctrl.write = req_q.wr;
				way_ctrl.en    = sel_onehot;
				done           = 1'b1;
				state_d        = IDLE;
			end
			default: begin
				err     = 1'b1;
				state_d = IDLE;
			end
		endcase

		if (wb_phase) begin
			mem_req.wr = 1'b1;
			mem_off    = way_off;
			mem_tag    = way_status[way_sel_q].tag;  // Victim line address
		end
		if (rd_phase) begin
			mem_req.rd = 1'b1;
		end
		if (fill_phase) begin
			way_ctrl.write    = 1'b1;
			way_ctrl.fill_sel = 1'b1;
			way_ctrl.en       = sel_onehot;
		end

		way_ctrl.offset = way_off;
		way_ctrl.wdata  = way_ctrl.fill_sel ? mem_rdata : cpu_wdata;
		mem_req.addr    = {mem_tag, way_ctrl.index, mem_off};
		mem_req.wdata   = way_status[way_sel_q].rdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q   <= IDLE;
			req_q     <= '0;
			victim_q  <= 1'b0;
			way_sel_q <= 1'b0;
		end else begin
			state_q   <= state_d;
			way_sel_q <= way_sel_d;
			victim_q  <= victim_q ^ done;  // Toggle on every completed request
			if (capture) begin
				req_q <= req;
			end
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n) !(req.rd && req.wr))
		else $error("cache_ctrl: rd and wr requested together");

	a_mem_one_strobe: assert property (
		@(posedge clk) disable iff (!arst_n) !(mem_req.rd && mem_req.wr)
	) else $error("cache_ctrl: memory rd and wr together");

	a_stall_release: assert property (@(posedge clk) disable iff (!arst_n) $fell(stall) |-> done)
		else $error("cache_ctrl: stall dropped without done");

endmodule

// File: cache/cache_way.sv
`timescale 1ns/1ps

module cache_way (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     enable,
	input  mem_sys_pkg::way_ctrl_t   way_ctrl,
	output mem_sys_pkg::way_status_t status
);
	import mem_sys_pkg::*;

	logic [TAG_W-1:0]      tag_mem  [NUM_SETS];
	logic [DATA_W-1:0]     data_mem [NUM_SETS][WORDS_PER_LINE];
	logic [NUM_SETS-1:0]   valid_q;
	logic [NUM_SETS-1:0]   dirty_q;
	logic [WORD_SEL_W-1:0] word_sel;
	logic                  line_valid;
	logic                  tag_match;
	logic                  line_hit;
	logic                  data_we;

	assign word_sel   = way_ctrl.offset[OFFSET_W-1:1];  // Words sit at even offsets
	assign line_valid = valid_q[way_ctrl.index];
	assign tag_match  = tag_mem[way_ctrl.index] == way_ctrl.tag;
	assign line_hit   = way_ctrl.comp & line_valid & tag_match;

	// Compare mode writes only on a hit, access mode always writes
	assign data_we = enable & way_ctrl.write & (line_hit | ~way_ctrl.comp);

	assign status.hit   = line_hit;
	assign status.valid = line_valid;
	assign status.dirty = dirty_q[way_ctrl.index];
	assign status.tag   = tag_mem[way_ctrl.index];
	assign status.rdata = data_mem[way_ctrl.index][word_sel];  // Combinational read

	always_ff @(posedge clk) begin
		if (data_we) begin
			data_mem[way_ctrl.index][word_sel] <= way_ctrl.wdata;
		end
		if (data_we && !way_ctrl.comp) begin
			tag_mem[way_ctrl.index] <= way_ctrl.tag;  // Install tag on fill
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (data_we) begin
			valid_q[way_ctrl.index] <= 1'b1;
			dirty_q[way_ctrl.index] <= ~way_ctrl.fill_sel;  // CPU write dirties, fill cleans
		end
	end

	// A missed compare write leaves the addressed word as it was
	a_no_miss_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		(enable && way_ctrl.comp && way_ctrl.write && !line_hit)
		|=> data_mem[$past(way_ctrl.index)][$past(word_sel)] == $past(status.rdata)
	) else $error("cache_way: data changed by a compare write that missed");

endmodule

// File: common/mem_sys_pkg.sv
package mem_sys_pkg;

	localparam int ADDR_W         = 16;
	localparam int DATA_W         = 16;
	localparam int OFFSET_W       = 3;  // Byte offset within a line
	localparam int INDEX_W        = 8;
	localparam int TAG_W          = 5;
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
	localparam int NUM_SETS       = 1 << INDEX_W;
	localparam int NUM_WAYS       = 2;
	localparam int MEM_LATENCY    = 2;  // Read strobe to data, in cycles
	localparam int NUM_BANKS      = 4;
	localparam int BANK_SEL_W     = $clog2(NUM_BANKS);
	localparam int ROW_W          = ADDR_W - 1 - BANK_SEL_W;
	localparam int BANK_ROWS      = 1 << ROW_W;

	typedef enum logic [3:0] {
		IDLE,
		ENABLE,
		WB0,         // Write-back of the victim line
		WB1,
		WB2,
		WB3,
		REQ0,        // Memory reads of the new line
		REQ1,
		REQ2_FILL0,  // Reads overlap the first fills
		REQ3_FILL1,
		FILL2,
		FILL3,
		DONE
	} ctrl_state_e;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} cpu_req_t;

	typedef struct packed {
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
		logic [TAG_W-1:0]    tag;
		logic                comp;      // Compare mode, else access mode
		logic                write;
		logic [DATA_W-1:0]   wdata;
		logic                fill_sel;  // Memory data, else CPU data
		logic [NUM_WAYS-1:0] en;
	} way_ctrl_t;

	typedef struct packed {
		logic              hit;
		logic              valid;
		logic              dirty;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] rdata;
	} way_status_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} mem_req_t;

endpackage
